//--- src/sram_chan_pkg.sv
package sram_chan_pkg;

    // ========================================================================
    // Datapath and buffer sizing
    // ========================================================================

    // Width of one data beat
    localparam int DATA_WIDTH = 32;

    // FIFO storage depth and pointer width
    localparam int FIFO_DEPTH = 16;
    localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

    // Counts and space values need one bit more than the pointer
    localparam int COUNT_WIDTH = ADDR_WIDTH + 1;

    // Burst reservation size from the read engine
    localparam int ALLOC_SIZE_WIDTH = 8;

    // Bridge skid buffer, plus one read in flight for the occupancy range
    localparam int SKID_DEPTH = 4;
    localparam int OCC_WIDTH  = 3;

    // ========================================================================
    // Bridge read slot
    // ========================================================================

    // Idle means no FIFO read outstanding
    typedef enum logic {
        SLOT_IDLE    = 1'b0,
        SLOT_PENDING = 1'b1
    } bridge_slot_e;

endpackage

//--- src/space_alloc_ctrl.sv
`timescale 1ns/1ps

module space_alloc_ctrl import sram_chan_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,

    // Burst reservation strobe from the read engine
    input  logic                        alloc_req,
    input  logic [ALLOC_SIZE_WIDTH-1:0] alloc_size,

    // One beat handed to the write engine
    input  logic                        beat_release,

    // Space not yet reserved
    output logic [COUNT_WIDTH-1:0]      space_free
);

    // Request decode
    logic                   alloc_fits;
    logic                   alloc_take;
    logic [COUNT_WIDTH-1:0] alloc_amount;

    // Release and combined update
    logic [COUNT_WIDTH-1:0] release_amount;
    logic [COUNT_WIDTH-1:0] space_next;

    // ========================================================================
    // Reservation decision
    // ========================================================================

    // Compare at the wider size width so large bursts are rejected
    assign alloc_fits   = alloc_size <= ALLOC_SIZE_WIDTH'(space_free);
    assign alloc_take   = alloc_req && alloc_fits;

    // Oversized requests are dropped, nothing is queued
    assign alloc_amount = alloc_take ? COUNT_WIDTH'(alloc_size) : '0;

    // Each output transfer returns one beat of space
    assign release_amount = COUNT_WIDTH'(beat_release);

    // Allocation and release may land on the same edge
    assign space_next = space_free - alloc_amount + release_amount;

    // ========================================================================
    // Reservation counter
    // ========================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // Whole buffer is free out of reset
            space_free <= COUNT_WIDTH'(FIFO_DEPTH);
        end else begin
            space_free <= space_next;
        end
    end

endmodule

//--- src/chan_fifo_sync.sv
`timescale 1ns/1ps

module chan_fifo_sync import sram_chan_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,

    // Write side, valid/ready from the read engine
    input  logic                   wr_valid,
    output logic                   wr_ready,
    input  logic [DATA_WIDTH-1:0]  wr_data,

    // Read side, pop with one cycle of read latency
    input  logic                   pop,
    output logic                   not_empty,
    output logic [DATA_WIDTH-1:0]  rd_data,
    output logic                   rd_data_valid,

    // Entries currently stored
    output logic [COUNT_WIDTH-1:0] count
);

    // Storage array
    logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];

    // Pointers carry a wrap bit above the index
    logic [ADDR_WIDTH:0]   wr_ptr;
    logic [ADDR_WIDTH:0]   rd_ptr;

    // Status and qualified strobes
    logic                  full;
    logic                  push;
    logic                  do_pop;

    // ========================================================================
    // Status
    // ========================================================================

    // Same index with opposite wrap bits means every entry is used
    assign full = (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                  (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);

    assign not_empty = (wr_ptr != rd_ptr);
    assign wr_ready  = !full;

    // Pointer difference wraps correctly thanks to the extra bit
    assign count = wr_ptr - rd_ptr;

    // Handshake and guarded pop
    assign push   = wr_valid && wr_ready;
    assign do_pop = pop && not_empty;

    // ========================================================================
    // Pointers
    // ========================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // ========================================================================
    // Storage and registered read port
    // ========================================================================

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= wr_data;
        end
    end

    // Read data holds until the next pop, like a real SRAM output latch
    always_ff @(posedge clk) begin
        if (do_pop) begin
            rd_data <= mem[rd_ptr[ADDR_WIDTH-1:0]];
        end
    end

    // Data valid for exactly the cycle after the pop edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_data_valid <= 1'b0;
        end else begin
            rd_data_valid <= do_pop;
        end
    end

endmodule

//--- src/read_latency_bridge.sv
`timescale 1ns/1ps

module read_latency_bridge import sram_chan_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,

    // FIFO read port
    input  logic                  fifo_not_empty,
    output logic                  fifo_pop,
    input  logic [DATA_WIDTH-1:0] fifo_rd_data,
    input  logic                  fifo_rd_data_valid,

    // Output stream toward the write engine
    output logic                  m_valid,
    input  logic                  m_ready,
    output logic [DATA_WIDTH-1:0] m_data,

    // Beats held here, skid plus the read in flight
    output logic [OCC_WIDTH-1:0]  occupancy,

    // Observation points
    output logic                  dbg_pending,
    output logic                  dbg_out_valid
);

    // Read slot state
    bridge_slot_e slot_state;
    bridge_slot_e slot_next;

    // Skid buffer storage and indices
    logic [DATA_WIDTH-1:0]         skid_mem [SKID_DEPTH];
    logic [$clog2(SKID_DEPTH)-1:0] skid_wr_idx;
    logic [$clog2(SKID_DEPTH)-1:0] skid_rd_idx;
    logic [OCC_WIDTH-1:0]          skid_count;

    // Skid strobes
    logic                          skid_push;
    logic                          out_fire;

    // ========================================================================
    // Read issue
    // ========================================================================

    // One read at a time, and only with a free skid entry for its return
    assign fifo_pop = (slot_state == SLOT_IDLE) && fifo_not_empty &&
                      (skid_count < OCC_WIDTH'(SKID_DEPTH));

    // Slot FSM
    always_comb begin
        slot_next = slot_state;
        case (slot_state)
            SLOT_IDLE: begin
                if (fifo_pop) begin
                    slot_next = SLOT_PENDING;
                end
            end
            SLOT_PENDING: begin
                // Returned beat is caught at the end of this cycle
                if (fifo_rd_data_valid) begin
                    slot_next = SLOT_IDLE;
                end
            end
            default: slot_next = SLOT_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_state <= SLOT_IDLE;
        end else begin
            slot_state <= slot_next;
        end
    end

    // ========================================================================
    // Skid buffer
    // ========================================================================

    assign skid_push = fifo_rd_data_valid;
    assign out_fire  = m_valid && m_ready;

    // Payload entries
    always_ff @(posedge clk) begin
        if (skid_push) begin
            skid_mem[skid_wr_idx] <= fifo_rd_data;
        end
    end

    // Indices wrap naturally, depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            skid_wr_idx <= '0;
            skid_rd_idx <= '0;
            skid_count  <= '0;
        end else begin
            if (skid_push) begin
                skid_wr_idx <= skid_wr_idx + 1'b1;
            end
            if (out_fire) begin
                skid_rd_idx <= skid_rd_idx + 1'b1;
            end
            skid_count <= skid_count + OCC_WIDTH'(skid_push) - OCC_WIDTH'(out_fire);
        end
    end

    // ========================================================================
    // Output and status
    // ========================================================================

    // Oldest beat is always on the output
    assign m_valid = (skid_count != '0);
    assign m_data  = skid_mem[skid_rd_idx];

    // Count the outstanding read as held data
    assign occupancy = skid_count + OCC_WIDTH'(slot_state == SLOT_PENDING);

    assign dbg_pending   = (slot_state == SLOT_PENDING);
    assign dbg_out_valid = m_valid;

endmodule

//--- src/sram_channel_unit.sv
`timescale 1ns/1ps

module sram_channel_unit import sram_chan_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,

    // Input stream from the read engine
    input  logic                        axi_rd_sram_valid,
    output logic                        axi_rd_sram_ready,
    input  logic [DATA_WIDTH-1:0]       axi_rd_sram_data,

    // Output stream to the write engine
    output logic                        axi_wr_sram_valid,
    input  logic                        axi_wr_sram_ready,
    output logic [DATA_WIDTH-1:0]       axi_wr_sram_data,

    // Burst allocation
    input  logic                        rd_alloc_req,
    input  logic [ALLOC_SIZE_WIDTH-1:0] rd_alloc_size,
    output logic [COUNT_WIDTH-1:0]      rd_space_free,

    // Status
    output logic [COUNT_WIDTH-1:0]      wr_data_available,
    output logic                        dbg_bridge_pending,
    output logic                        dbg_bridge_out_valid
);

    // Allocator
    logic                   out_release;
    logic [COUNT_WIDTH-1:0] alloc_space_free;

    // FIFO to bridge
    logic                   fifo_not_empty;
    logic                   fifo_pop;
    logic [DATA_WIDTH-1:0]  fifo_rd_data;
    logic                   fifo_rd_data_valid;
    logic [COUNT_WIDTH-1:0] fifo_count;

    // Beats held inside the bridge
    logic [OCC_WIDTH-1:0]   bridge_occupancy;

    // ========================================================================
    // Space allocation
    // ========================================================================

    // Space comes back once a beat leaves the channel
    assign out_release = axi_wr_sram_valid && axi_wr_sram_ready;

    space_alloc_ctrl u_alloc_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .alloc_req    (rd_alloc_req),
        .alloc_size   (rd_alloc_size),
        .beat_release (out_release),
        .space_free   (alloc_space_free)
    );

    // Extra register stage toward the read engine
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_space_free <= COUNT_WIDTH'(FIFO_DEPTH);
        end else begin
            rd_space_free <= alloc_space_free;
        end
    end

    // ========================================================================
    // Data path
    // ========================================================================

    // Input ready follows FIFO full directly
    chan_fifo_sync u_chan_fifo (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_valid      (axi_rd_sram_valid),
        .wr_ready      (axi_rd_sram_ready),
        .wr_data       (axi_rd_sram_data),
        .pop           (fifo_pop),
        .not_empty     (fifo_not_empty),
        .rd_data       (fifo_rd_data),
        .rd_data_valid (fifo_rd_data_valid),
        .count         (fifo_count)
    );

    read_latency_bridge u_latency_bridge (
        .clk                (clk),
        .rst_n              (rst_n),
        .fifo_not_empty     (fifo_not_empty),
        .fifo_pop           (fifo_pop),
        .fifo_rd_data       (fifo_rd_data),
        .fifo_rd_data_valid (fifo_rd_data_valid),
        .m_valid            (axi_wr_sram_valid),
        .m_ready            (axi_wr_sram_ready),
        .m_data             (axi_wr_sram_data),
        .occupancy          (bridge_occupancy),
        .dbg_pending        (dbg_bridge_pending),
        .dbg_out_valid      (dbg_bridge_out_valid)
    );

    // Held beats, FIFO entries plus bridge contents, combinational
    assign wr_data_available = fifo_count + COUNT_WIDTH'(bridge_occupancy);

endmodule

//--- testbench/tb_sram_channel_unit.sv
`timescale 1ns/1ps

module tb_sram_channel_unit import sram_chan_pkg::*; ();

    localparam int RAND_BEATS = 400;
    localparam int WAIT_LIMIT = 4000;

    logic                        clk;
    logic                        rst_n;
    logic                        axi_rd_sram_valid;
    logic                        axi_rd_sram_ready;
    logic [DATA_WIDTH-1:0]       axi_rd_sram_data;
    logic                        axi_wr_sram_valid;
    logic                        axi_wr_sram_ready;
    logic [DATA_WIDTH-1:0]       axi_wr_sram_data;
    logic                        rd_alloc_req;
    logic [ALLOC_SIZE_WIDTH-1:0] rd_alloc_size;
    logic [COUNT_WIDTH-1:0]      rd_space_free;
    logic [COUNT_WIDTH-1:0]      wr_data_available;
    logic                        dbg_bridge_pending;
    logic                        dbg_bridge_out_valid;

    // Reference model state advanced once per cycle
    logic [DATA_WIDTH-1:0]       exp_q [$];
    logic [COUNT_WIDTH-1:0]      held_model;
    logic [COUNT_WIDTH-1:0]      space_model;
    logic [COUNT_WIDTH-1:0]      space_out;

    // Read engine side of the stimulus
    logic                        have_beat;
    logic [DATA_WIDTH-1:0]       beat;
    logic                        in_fire;
    logic                        out_seen;
    int                          accepted;

    sram_channel_unit uut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ========================================================================
    // Compare tasks and abort
    // ========================================================================

    task automatic check_data(input string name, input logic [DATA_WIDTH-1:0] exp,
                              input logic [DATA_WIDTH-1:0] act);
        if (exp !== act) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            $display("TESTBENCH FAILED");
            $fatal(1, "Data mismatch in %s", name);
        end
    endtask

    task automatic check_count(input string name, input logic [COUNT_WIDTH-1:0] exp,
                               input logic [COUNT_WIDTH-1:0] act);
        if (exp !== act) begin
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
            $display("TESTBENCH FAILED");
            $fatal(1, "Count mismatch in %s", name);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("Fail %s: expected %b, actual %b", name, exp, act);
            $display("TESTBENCH FAILED");
            $fatal(1, "Bit mismatch in %s", name);
        end
    endtask

    task automatic abort_timeout(input string what);
        $display("TESTBENCH FAILED");
        $fatal(1, "Timeout: %s", what);
    endtask

    // ========================================================================
    // One clock cycle of checking, driving and model update
    // ========================================================================

    task automatic step(input logic in_valid, input logic [DATA_WIDTH-1:0] in_data,
                        input logic out_ready, input logic a_req,
                        input logic [ALLOC_SIZE_WIDTH-1:0] a_size);
        logic out_fire;
        @(negedge clk);
        // Status reflects every edge seen so far
        check_count("held_count", held_model, wr_data_available);
        check_count("space_free", space_out, rd_space_free);
        out_seen          = axi_wr_sram_valid;
        axi_rd_sram_valid = in_valid;
        axi_rd_sram_data  = in_data;
        axi_wr_sram_ready = out_ready;
        rd_alloc_req      = a_req;
        rd_alloc_size     = a_size;
        // Ready and valid come from registers only, so both are final here
        in_fire  = in_valid && axi_rd_sram_ready;
        out_fire = axi_wr_sram_valid && out_ready;
        if (out_fire && exp_q.size() == 0) begin
            $display("TESTBENCH FAILED");
            $fatal(1, "Output beat delivered while none was outstanding");
        end else if (out_fire) begin
            check_data("beat_order", exp_q.pop_front(), axi_wr_sram_data);
        end
        if (in_fire) begin
            exp_q.push_back(in_data);
            accepted++;
        end
        held_model = held_model + COUNT_WIDTH'(in_fire) - COUNT_WIDTH'(out_fire);
        // Output register trails the allocator by one edge
        space_out = space_model;
        if (a_req && int'(a_size) <= int'(space_model)) begin
            space_model = space_model - COUNT_WIDTH'(a_size);
        end
        space_model = space_model + COUNT_WIDTH'(out_fire);
    endtask

    // Valid holds its beat until accepted; one request in five is oversized
    task automatic send_cycle(input int valid_pct, input int ready_pct, input int alloc_pct);
        logic                        req;
        logic [ALLOC_SIZE_WIDTH-1:0] size;
        if (!have_beat && $urandom_range(99, 0) < valid_pct) begin
            have_beat = 1'b1;
            beat      = $urandom();
        end
        req  = $urandom_range(99, 0) < alloc_pct;
        size = ($urandom_range(4, 0) == 0) ? ALLOC_SIZE_WIDTH'($urandom_range(255, 17))
                                           : ALLOC_SIZE_WIDTH'($urandom_range(6, 0));
        step(have_beat, beat, $urandom_range(99, 0) < ready_pct, req, size);
        if (in_fire) begin
            have_beat = 1'b0;
        end
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================

    initial begin
        int           lat;
        int           waited;
        bridge_slot_e slot_seen;
        void'($urandom(32'h24079d56));
        rst_n = 1'b0;
        axi_rd_sram_valid = 1'b0;
        axi_rd_sram_data  = '0;
        axi_wr_sram_ready = 1'b0;
        rd_alloc_req      = 1'b0;
        rd_alloc_size     = '0;
        held_model  = '0;
        space_model = COUNT_WIDTH'(FIFO_DEPTH);
        space_out   = COUNT_WIDTH'(FIFO_DEPTH);
        have_beat   = 1'b0;
        beat        = '0;
        in_fire     = 1'b0;
        out_seen    = 1'b0;
        accepted    = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Idle channel out of reset
        check_bit("reset_out_valid", 1'b0, axi_wr_sram_valid);
        check_bit("reset_dbg_pending", 1'b0, dbg_bridge_pending);
        check_bit("reset_dbg_out_valid", 1'b0, dbg_bridge_out_valid);
        check_bit("reset_in_ready", 1'b1, axi_rd_sram_ready);
        check_count("reset_available", '0, wr_data_available);
        check_count("reset_space", COUNT_WIDTH'(FIFO_DEPTH), rd_space_free);

        // Reserve one beat then send a single beat into the empty channel
        step(1'b0, '0, 1'b1, 1'b1, ALLOC_SIZE_WIDTH'(1));
        step(1'b1, 32'hc0de_0001, 1'b1, 1'b0, '0);
        check_bit("latency_accept", 1'b1, in_fire);
        lat = 0;
        step(1'b0, '0, 1'b1, 1'b0, '0);
        while (!out_seen && lat < 20) begin
            lat++;
            step(1'b0, '0, 1'b1, 1'b0, '0);
            // Read slot is busy only in the cycle after the pop edge
            check_bit("latency_pending", lat == 1, dbg_bridge_pending);
        end
        if (!out_seen) abort_timeout("single beat never reached the output");
        check_count("latency_cycles", COUNT_WIDTH'(2), COUNT_WIDTH'(lat));
        check_bit("latency_dbg_out_valid", 1'b1, dbg_bridge_out_valid);

        // Fill with the output stalled until input ready drops
        step(1'b0, '0, 1'b0, 1'b1, ALLOC_SIZE_WIDTH'(FIFO_DEPTH));
        accepted = 0;
        waited   = 0;
        send_cycle(100, 0, 0);
        while (in_fire && waited < WAIT_LIMIT) begin
            waited++;
            send_cycle(100, 0, 0);
        end
        if (in_fire) abort_timeout("input ready never dropped under back-pressure");
        repeat (4) send_cycle(100, 0, 0);
        slot_seen = bridge_slot_e'(dbg_bridge_pending);
        $display("Back-pressure: %0d beats held, bridge slot %s", accepted, slot_seen.name());
        check_count("bp_accepted", COUNT_WIDTH'(FIFO_DEPTH + SKID_DEPTH), COUNT_WIDTH'(accepted));
        check_bit("bp_in_ready", 1'b0, axi_rd_sram_ready);
        check_bit("bp_pending", 1'b0, dbg_bridge_pending);

        // Drain while the held input beat goes in as space opens
        waited = 0;
        while ((have_beat || held_model != '0) && waited < WAIT_LIMIT) begin
            waited++;
            send_cycle(0, 100, 0);
        end
        if (have_beat || held_model != '0) abort_timeout("back-pressure drain stalled");

        // Random traffic mixed with allocation requests
        accepted = 0;
        waited   = 0;
        while (accepted < RAND_BEATS && waited < 20 * RAND_BEATS) begin
            waited++;
            send_cycle(70, 60, 25);
        end
        if (accepted < RAND_BEATS) abort_timeout("random traffic stopped accepting beats");
        waited = 0;
        while ((have_beat || held_model != '0) && waited < WAIT_LIMIT) begin
            waited++;
            send_cycle(0, 100, 0);
        end
        if (have_beat || held_model != '0) abort_timeout("final drain stalled");
        step(1'b0, '0, 1'b1, 1'b0, '0);
        step(1'b0, '0, 1'b1, 1'b0, '0);

        // Empty channel is idle again
        check_bit("final_out_valid", 1'b0, axi_wr_sram_valid);
        check_bit("final_dbg_out_valid", 1'b0, dbg_bridge_out_valid);
        check_bit("final_dbg_pending", 1'b0, dbg_bridge_pending);
        check_bit("final_in_ready", 1'b1, axi_rd_sram_ready);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- build.f
src/sram_chan_pkg.sv
src/space_alloc_ctrl.sv
src/chan_fifo_sync.sv
src/read_latency_bridge.sv
src/sram_channel_unit.sv
testbench/tb_sram_channel_unit.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -f build.f --top-module tb_sram_channel_unit \
    --Mdir obj_dir -o tb_sim &&
./obj_dir/tb_sim ||
{ echo "Simulation did not pass"; exit 1; }
